// File: design/icache_tag_pkg.sv
// fixed geometry of 4 ways, 64 sets of 64-byte lines and 32-bit fetch addresses; valid is one bit
package icache_tag_pkg;

  // address split
  localparam int unsigned ADDR_WIDTH          = 32;
  localparam int unsigned OFFSET_WIDTH        = 6;   // 64-byte lines
  localparam int unsigned BANK_SEL_WIDTH      = 2;   // low bits of the set index
  localparam int unsigned SETS_PER_BANK_WIDTH = 4;   // 16 sets per bank
  localparam int unsigned SET_WIDTH           = SETS_PER_BANK_WIDTH + BANK_SEL_WIDTH;
  localparam int unsigned TAG_WIDTH           = ADDR_WIDTH - SET_WIDTH - OFFSET_WIDTH;

  // array shape
  localparam int unsigned NUM_WAYS      = 4;
  localparam int unsigned WAY_IDX_WIDTH = $clog2(NUM_WAYS);
  localparam int unsigned NUM_BANKS     = 1 << BANK_SEL_WIDTH;

  typedef struct packed {
    logic [TAG_WIDTH-1:0]           tag;
    logic [SETS_PER_BANK_WIDTH-1:0] bank_addr;
    logic [BANK_SEL_WIDTH-1:0]      bank_sel;
    logic [OFFSET_WIDTH-1:0]        offset;
  } fetch_addr_t;

  // one stored tag entry
  typedef struct packed {
    logic [TAG_WIDTH-1:0] tag;
    logic                 valid;
  } tag_entry_t;

  typedef logic [NUM_WAYS-1:0] way_vec_t;

  typedef struct packed {
    fetch_addr_t addr;
  } lookup_req_t;

  // way vectors are one-hot or zero
  typedef struct packed {
    logic     hit_a;
    way_vec_t way_a;
    logic     hit_b;
    way_vec_t way_b;
  } lookup_rsp_t;

  typedef enum logic {
    FILL  = 1'b0,
    FLUSH = 1'b1
  } fill_op_e;

  typedef struct packed {
    fill_op_e    op;
    fetch_addr_t addr;
  } refill_req_t;

  // write port command into the tag array
  typedef struct packed {
    logic                           we;
    way_vec_t                       way_mask;
    logic [SETS_PER_BANK_WIDTH-1:0] bank_addr;
    logic [BANK_SEL_WIDTH-1:0]      bank_sel;
    tag_entry_t                     entry;
  } tag_wr_t;

endpackage

// File: design/sram.sv
// storage is not initialized; a read in the cycle of a write to the same address gets old data
`timescale 1ns/1ps

module sram #(
  parameter int unsigned DATA_WIDTH = 21,
  parameter int unsigned ADDR_WIDTH = 4
) (
  input  logic                  clk_i,

  // write port
  input  logic                  we_i,
  input  logic [ADDR_WIDTH-1:0] waddr_i,
  input  logic [DATA_WIDTH-1:0] wdata_i,

  // two read ports
  input  logic [ADDR_WIDTH-1:0] addr_ra_i,
  input  logic [ADDR_WIDTH-1:0] addr_rb_i,
  output logic [DATA_WIDTH-1:0] rdata_ra_o,
  output logic [DATA_WIDTH-1:0] rdata_rb_o
);

  localparam int unsigned DEPTH = 1 << ADDR_WIDTH;

  logic [DATA_WIDTH-1:0] mem [DEPTH];
  logic [DATA_WIDTH-1:0] rdata_ra_q;
  logic [DATA_WIDTH-1:0] rdata_rb_q;

  always_ff @(posedge clk_i) begin
    if (we_i) begin
      mem[waddr_i] <= wdata_i;
    end
  end

  // registered reads, one cycle latency
  always_ff @(posedge clk_i) begin
    rdata_ra_q <= mem[addr_ra_i];
    rdata_rb_q <= mem[addr_rb_i];
  end

  assign rdata_ra_o = rdata_ra_q;
  assign rdata_rb_o = rdata_rb_q;

endmodule

// File: design/tag_array.sv
// read data appears one cycle after the address; reads racing a write to the same set see old tags
`timescale 1ns/1ps

module tag_array (
  input  logic                                              clk_i,
  input  logic                                              rst_n_i,

  // read port A, line A
  input  logic [icache_tag_pkg::SETS_PER_BANK_WIDTH-1:0]    bank_addr_ra_i,
  input  logic [icache_tag_pkg::BANK_SEL_WIDTH-1:0]         bank_sel_ra_i,

  // read port B, next line
  input  logic [icache_tag_pkg::SETS_PER_BANK_WIDTH-1:0]    bank_addr_rb_i,
  input  logic [icache_tag_pkg::BANK_SEL_WIDTH-1:0]         bank_sel_rb_i,

  input  icache_tag_pkg::tag_wr_t                           tag_wr_i,

  output icache_tag_pkg::tag_entry_t [icache_tag_pkg::NUM_WAYS-1:0] rdata_a_o,
  output icache_tag_pkg::tag_entry_t [icache_tag_pkg::NUM_WAYS-1:0] rdata_b_o
);

  import icache_tag_pkg::*;

  logic                      cell_we   [NUM_WAYS][NUM_BANKS];
  tag_entry_t                cell_rd_a [NUM_WAYS][NUM_BANKS];
  tag_entry_t                cell_rd_b [NUM_WAYS][NUM_BANKS];
  logic [BANK_SEL_WIDTH-1:0] sel_a_q;
  logic [BANK_SEL_WIDTH-1:0] sel_b_q;

  for (genvar w = 0; w < NUM_WAYS; w++) begin : gen_way
    for (genvar b = 0; b < NUM_BANKS; b++) begin : gen_bank
      // way mask bit and matching bank
      assign cell_we[w][b] = tag_wr_i.we && tag_wr_i.way_mask[w] &&
                             (tag_wr_i.bank_sel == BANK_SEL_WIDTH'(b));

      sram #(
        .DATA_WIDTH ($bits(tag_entry_t)),
        .ADDR_WIDTH (SETS_PER_BANK_WIDTH)
      ) u_sram (
        .clk_i      (clk_i),
        .we_i       (cell_we[w][b]),
        .waddr_i    (tag_wr_i.bank_addr),
        .wdata_i    (tag_wr_i.entry),
        .addr_ra_i  (bank_addr_ra_i),
        .addr_rb_i  (bank_addr_rb_i),
        .rdata_ra_o (cell_rd_a[w][b]),
        .rdata_rb_o (cell_rd_b[w][b])
      );
    end
  end

  // bank selects follow the sram read register
  always_ff @(posedge clk_i or negedge rst_n_i) begin
    if (!rst_n_i) begin
      sel_a_q <= '0;
      sel_b_q <= '0;
    end else begin
      sel_a_q <= bank_sel_ra_i;
      sel_b_q <= bank_sel_rb_i;
    end
  end

  always_comb begin
    for (int w = 0; w < NUM_WAYS; w++) begin
      rdata_a_o[w] = cell_rd_a[w][sel_a_q];
      rdata_b_o[w] = cell_rd_b[w][sel_b_q];
    end
  end

  // the refill side must always name at least one way
  a_wr_mask_nonzero: assert property (
    @(posedge clk_i) disable iff (!rst_n_i)
    tag_wr_i.we |-> (|tag_wr_i.way_mask)
  ) else $error("tag write with empty way mask");

endmodule

// File: design/tag_lookup.sv
// requester must hold req and the address until ack; line B after the last set wraps with tag + 1
`timescale 1ns/1ps

module tag_lookup (
  input  logic                                              clk_i,
  input  logic                                              rst_n_i,

  // four-phase lookup handshake
  input  logic                                              req_i,
  input  icache_tag_pkg::lookup_req_t                       req_data_i,
  output logic                                              ack_o,
  output icache_tag_pkg::lookup_rsp_t                       rsp_o,

  // read addresses into the tag array
  output logic [icache_tag_pkg::SETS_PER_BANK_WIDTH-1:0]    bank_addr_ra_o,
  output logic [icache_tag_pkg::BANK_SEL_WIDTH-1:0]         bank_sel_ra_o,
  output logic [icache_tag_pkg::SETS_PER_BANK_WIDTH-1:0]    bank_addr_rb_o,
  output logic [icache_tag_pkg::BANK_SEL_WIDTH-1:0]         bank_sel_rb_o,

  // tags read back one cycle later
  input  icache_tag_pkg::tag_entry_t [icache_tag_pkg::NUM_WAYS-1:0] rdata_a_i,
  input  icache_tag_pkg::tag_entry_t [icache_tag_pkg::NUM_WAYS-1:0] rdata_b_i
);

  import icache_tag_pkg::*;

  localparam int unsigned LINE_WIDTH = TAG_WIDTH + SET_WIDTH;

  typedef enum logic [1:0] {
    S_IDLE,
    S_READ,
    S_COMPARE,
    S_ACK
  } state_e;

  state_e                state_q, state_d;
  logic [LINE_WIDTH-1:0] line_a;
  logic [LINE_WIDTH-1:0] line_b;
  fetch_addr_t           addr_a_q;
  fetch_addr_t           addr_b_q;
  way_vec_t              match_a;
  way_vec_t              match_b;
  lookup_rsp_t           rsp_q;

  // line number plus one carries into the tag
  assign line_a = {req_data_i.addr.tag, req_data_i.addr.bank_addr, req_data_i.addr.bank_sel};
  assign line_b = line_a + 1'b1;

  always_comb begin
    state_d = state_q;
    case (state_q)
      S_IDLE:    if (req_i) state_d = S_READ;
      S_READ:    state_d = S_COMPARE;  // sram read in flight
      S_COMPARE: state_d = S_ACK;
      S_ACK:     if (!req_i) state_d = S_IDLE;
      default:   state_d = S_IDLE;
    endcase
  end

  always_ff @(posedge clk_i or negedge rst_n_i) begin
    if (!rst_n_i) begin
      state_q <= S_IDLE;
    end else begin
      state_q <= state_d;
    end
  end

  // both addresses held until the compare is done
  always_ff @(posedge clk_i) begin
    if (state_q == S_IDLE && req_i) begin
      addr_a_q <= req_data_i.addr;
      addr_b_q <= {line_b, {OFFSET_WIDTH{1'b0}}};
    end
  end

  assign bank_addr_ra_o = addr_a_q.bank_addr;
  assign bank_sel_ra_o  = addr_a_q.bank_sel;
  assign bank_addr_rb_o = addr_b_q.bank_addr;
  assign bank_sel_rb_o  = addr_b_q.bank_sel;

  always_comb begin
    for (int w = 0; w < NUM_WAYS; w++) begin
      match_a[w] = rdata_a_i[w].valid && (rdata_a_i[w].tag == addr_a_q.tag);
      match_b[w] = rdata_b_i[w].valid && (rdata_b_i[w].tag == addr_b_q.tag);
    end
  end

  always_ff @(posedge clk_i) begin
    if (state_q == S_COMPARE) begin
      rsp_q <= '{hit_a: |match_a, way_a: match_a, hit_b: |match_b, way_b: match_b};
    end
  end

  assign ack_o = (state_q == S_ACK);
  assign rsp_o = rsp_q;

  // a set never holds the same valid tag twice
  a_way_onehot: assert property (
    @(posedge clk_i) disable iff (!rst_n_i)
    ack_o |-> ($onehot0(rsp_q.way_a) && $onehot0(rsp_q.way_b))
  ) else $error("lookup hit in more than one way");

  a_ack_needs_req: assert property (
    @(posedge clk_i) disable iff (!rst_n_i)
    $rose(ack_o) |-> req_i
  ) else $error("lookup ack raised without req");

endmodule

// File: design/refill_ctrl.sv
// one write per request; the victim pointer is global across sets and only FILL advances it
`timescale 1ns/1ps

module refill_ctrl (
  input  logic                        clk_i,
  input  logic                        rst_n_i,

  // four-phase refill handshake
  input  logic                        req_i,
  input  icache_tag_pkg::refill_req_t req_data_i,
  output logic                        ack_o,

  output icache_tag_pkg::tag_wr_t     tag_wr_o
);

  import icache_tag_pkg::*;

  typedef enum logic [1:0] {
    S_IDLE,
    S_WRITE,
    S_ACK
  } state_e;

  state_e                         state_q, state_d;
  logic                           start;
  logic [WAY_IDX_WIDTH-1:0]       victim_q;
  way_vec_t                       mask_q;
  logic [SETS_PER_BANK_WIDTH-1:0] bank_addr_q;
  logic [BANK_SEL_WIDTH-1:0]      bank_sel_q;
  tag_entry_t                     entry_q;

  assign start = (state_q == S_IDLE) && req_i;

  always_comb begin
    state_d = state_q;
    case (state_q)
      S_IDLE:  if (req_i) state_d = S_WRITE;
      S_WRITE: state_d = S_ACK;           // write lands on this edge
      S_ACK:   if (!req_i) state_d = S_IDLE;  // hold ack until req falls
      default: state_d = S_IDLE;
    endcase
  end

  always_ff @(posedge clk_i or negedge rst_n_i) begin
    if (!rst_n_i) begin
      state_q  <= S_IDLE;
      victim_q <= '0;
    end else begin
      state_q <= state_d;
      if (start && req_data_i.op == FILL) begin
        victim_q <= victim_q + 1'b1;  // wraps at NUM_WAYS
      end
    end
  end

  // write command captured with the request
  always_ff @(posedge clk_i) begin
    if (start) begin
      bank_addr_q <= req_data_i.addr.bank_addr;
      bank_sel_q  <= req_data_i.addr.bank_sel;
      if (req_data_i.op == FILL) begin
        mask_q  <= way_vec_t'(1) << victim_q;
        entry_q <= '{tag: req_data_i.addr.tag, valid: 1'b1};
      end else begin
        // flush clears every way of the set
        mask_q  <= '1;
        entry_q <= '{tag: req_data_i.addr.tag, valid: 1'b0};
      end
    end
  end

  assign tag_wr_o = '{
    we:        (state_q == S_WRITE),
    way_mask:  mask_q,
    bank_addr: bank_addr_q,
    bank_sel:  bank_sel_q,
    entry:     entry_q
  };

  assign ack_o = (state_q == S_ACK);

  a_we_single: assert property (
    @(posedge clk_i) disable iff (!rst_n_i)
    tag_wr_o.we |=> !tag_wr_o.we
  ) else $error("tag write enable held longer than one cycle");

endmodule

// File: design/icache_tag_top.sv
// no ordering between lookup and refill; a lookup racing a write to its set may see old tags
`timescale 1ns/1ps

module icache_tag_top (
  input  logic                        clk_i,
  input  logic                        rst_n_i,

  // lookup requester
  input  logic                        lookup_req_i,
  input  icache_tag_pkg::lookup_req_t lookup_req_data_i,
  output logic                        lookup_ack_o,
  output icache_tag_pkg::lookup_rsp_t lookup_rsp_o,

  // refill requester
  input  logic                        refill_req_i,
  input  icache_tag_pkg::refill_req_t refill_data_i,
  output logic                        refill_ack_o
);

  import icache_tag_pkg::*;

  logic [SETS_PER_BANK_WIDTH-1:0]  bank_addr_ra;
  logic [BANK_SEL_WIDTH-1:0]       bank_sel_ra;
  logic [SETS_PER_BANK_WIDTH-1:0]  bank_addr_rb;
  logic [BANK_SEL_WIDTH-1:0]       bank_sel_rb;
  tag_entry_t [NUM_WAYS-1:0]       rdata_a;
  tag_entry_t [NUM_WAYS-1:0]       rdata_b;
  tag_wr_t                         tag_wr;

  tag_lookup u_tag_lookup (
    .clk_i          (clk_i),
    .rst_n_i        (rst_n_i),
    .req_i          (lookup_req_i),
    .req_data_i     (lookup_req_data_i),
    .ack_o          (lookup_ack_o),
    .rsp_o          (lookup_rsp_o),
    .bank_addr_ra_o (bank_addr_ra),
    .bank_sel_ra_o  (bank_sel_ra),
    .bank_addr_rb_o (bank_addr_rb),
    .bank_sel_rb_o  (bank_sel_rb),
    .rdata_a_i      (rdata_a),
    .rdata_b_i      (rdata_b)
  );

  refill_ctrl u_refill_ctrl (
    .clk_i      (clk_i),
    .rst_n_i    (rst_n_i),
    .req_i      (refill_req_i),
    .req_data_i (refill_data_i),
    .ack_o      (refill_ack_o),
    .tag_wr_o   (tag_wr)
  );

  tag_array u_tag_array (
    .clk_i          (clk_i),
    .rst_n_i        (rst_n_i),
    .bank_addr_ra_i (bank_addr_ra),
    .bank_sel_ra_i  (bank_sel_ra),
    .bank_addr_rb_i (bank_addr_rb),
    .bank_sel_rb_i  (bank_sel_rb),
    .tag_wr_i       (tag_wr),
    .rdata_a_o      (rdata_a),
    .rdata_b_o      (rdata_b)
  );

endmodule

// File: tests/tb_icache_tag.sv
// tag contents start unknown until the first full flush; lookups and refills never overlap here
`timescale 1ns/1ps

module tb_icache_tag;

  import icache_tag_pkg::*;

  localparam int unsigned NUM_SETS    = 1 << SET_WIDTH;
  localparam int unsigned ACK_TIMEOUT = 20;  // cycles per handshake phase
  localparam int unsigned HOLD_CYCLES = 4;

  // handshake timing in cycles after the edge that drives req
  localparam int unsigned LOOKUP_ACK_LATENCY = 3;
  localparam int unsigned REFILL_ACK_LATENCY = 2;
  localparam int unsigned ACK_DROP_LATENCY   = 1;

  logic        clk_i = 1'b0;
  logic        rst_n_i;
  logic        lookup_req_i;
  lookup_req_t lookup_req_data_i;
  logic        lookup_ack_o;
  lookup_rsp_t lookup_rsp_o;
  logic        refill_req_i;
  refill_req_t refill_data_i;
  logic        refill_ack_o;

  // reference tag model
  logic [TAG_WIDTH-1:0] model_tag   [NUM_SETS][NUM_WAYS];
  logic                 model_valid [NUM_SETS][NUM_WAYS];
  int unsigned          model_victim;

  logic [31:0] rng_state;
  lookup_rsp_t expected_rsp;
  fetch_addr_t cur_addr;
  int          check_count;
  int          error_count;
  int          test_errors;
  int          test_num;
  int          tests_passed;
  int          tests_failed;

  icache_tag_top DUT (
    .clk_i             (clk_i),
    .rst_n_i           (rst_n_i),
    .lookup_req_i      (lookup_req_i),
    .lookup_req_data_i (lookup_req_data_i),
    .lookup_ack_o      (lookup_ack_o),
    .lookup_rsp_o      (lookup_rsp_o),
    .refill_req_i      (refill_req_i),
    .refill_data_i     (refill_data_i),
    .refill_ack_o      (refill_ack_o)
  );

  always #10 clk_i = ~clk_i;

  function automatic logic [31:0] next_rand();
    rng_state ^= rng_state << 13;
    rng_state ^= rng_state >> 17;
    rng_state ^= rng_state << 5;
    return rng_state;
  endfunction

  function automatic fetch_addr_t make_addr(input logic [TAG_WIDTH-1:0] tag,
                                            input logic [SET_WIDTH-1:0] set,
                                            input logic [OFFSET_WIDTH-1:0] offset);
    return fetch_addr_t'({tag, set, offset});  // set = {bank_addr, bank_sel}
  endfunction

  function automatic bit tag_in_set(input logic [SET_WIDTH-1:0] set,
                                    input logic [TAG_WIDTH-1:0] tag);
    for (int w = 0; w < NUM_WAYS; w++) begin
      if (model_valid[set][w] && model_tag[set][w] == tag) return 1'b1;
    end
    return 1'b0;
  endfunction

  // expected response: line B is the next line number, carrying into the tag
  function automatic lookup_rsp_t expected_lookup(input fetch_addr_t addr);
    lookup_rsp_t                    rsp;
    logic [TAG_WIDTH+SET_WIDTH-1:0] line_a;
    logic [TAG_WIDTH+SET_WIDTH-1:0] line_b;
    logic [SET_WIDTH-1:0]           set_a;
    logic [SET_WIDTH-1:0]           set_b;
    line_a = addr[ADDR_WIDTH-1:OFFSET_WIDTH];
    line_b = line_a + 1'b1;
    set_a  = line_a[SET_WIDTH-1:0];
    set_b  = line_b[SET_WIDTH-1:0];
    rsp    = '0;
    for (int w = 0; w < NUM_WAYS; w++) begin
      rsp.way_a[w] = model_valid[set_a][w] && (model_tag[set_a][w] == line_a[SET_WIDTH +: TAG_WIDTH]);
      rsp.way_b[w] = model_valid[set_b][w] && (model_tag[set_b][w] == line_b[SET_WIDTH +: TAG_WIDTH]);
    end
    rsp.hit_a = |rsp.way_a;
    rsp.hit_b = |rsp.way_b;
    return rsp;
  endfunction

  function automatic string rsp_text(input lookup_rsp_t rsp);
    return $sformatf("hit_a=%0b way_a=%b hit_b=%0b way_b=%b",
                     rsp.hit_a, rsp.way_a, rsp.hit_b, rsp.way_b);
  endfunction

  task automatic report_hang(input string what);
    $display("handshake hang at %0t: %s did not happen within %0d cycles",
             $time, what, ACK_TIMEOUT);
    $display("Simulation failed");
    $finish;
  endtask

  // samples ack at the falling edge, away from the driving edge
  task automatic wait_ack(input bit lookup_side, input logic level,
                          input int unsigned latency, input string what);
    int   cycles;
    logic ack;
    cycles = 0;
    @(negedge clk_i);
    ack = lookup_side ? lookup_ack_o : refill_ack_o;
    while (ack !== level && cycles < ACK_TIMEOUT) begin
      @(negedge clk_i);
      ack = lookup_side ? lookup_ack_o : refill_ack_o;
      cycles++;
    end
    if (ack !== level) begin
      report_hang(what);
    end else if (cycles != latency) begin
      error_count++;
      test_errors++;
      $display("CHECK FAILED at %0t: %s after %0d cycles, expected %0d", $time, what,
               cycles, latency);
    end
  endtask

  task automatic run_refill(input fill_op_e op, input fetch_addr_t addr);
    logic [SET_WIDTH-1:0] set;
    set = {addr.bank_addr, addr.bank_sel};
    @(posedge clk_i);
    refill_data_i <= '{op: op, addr: addr};
    refill_req_i  <= 1'b1;
    wait_ack(1'b0, 1'b1, REFILL_ACK_LATENCY, "refill ack rise");
    @(posedge clk_i);
    refill_req_i <= 1'b0;
    wait_ack(1'b0, 1'b0, ACK_DROP_LATENCY, "refill ack fall");
    if (op == FILL) begin
      model_tag[set][model_victim]   = addr.tag;
      model_valid[set][model_victim] = 1'b1;
      model_victim = (model_victim + 1) % NUM_WAYS;  // global round robin
    end else begin
      for (int w = 0; w < NUM_WAYS; w++) model_valid[set][w] = 1'b0;
    end
  endtask

  // bumps the tag if the set already holds it, so no set has duplicates
  task automatic fill_tag(input logic [SET_WIDTH-1:0] set, input logic [TAG_WIDTH-1:0] tag,
                          output logic [TAG_WIDTH-1:0] used);
    used = tag;
    while (tag_in_set(set, used)) used = used + 1'b1;
    run_refill(FILL, make_addr(used, set, '0));
  endtask

  task automatic flush_all();
    for (int s = 0; s < NUM_SETS; s++) begin
      run_refill(FLUSH, make_addr('0, SET_WIDTH'(s), '0));
    end
  endtask

  task automatic run_lookup(input fetch_addr_t addr, input int hold);
    cur_addr     = addr;
    expected_rsp = expected_lookup(addr);
    @(posedge clk_i);
    lookup_req_data_i <= '{addr: addr};
    lookup_req_i      <= 1'b1;
    wait_ack(1'b1, 1'b1, LOOKUP_ACK_LATENCY, "lookup ack rise");
    repeat (hold) @(negedge clk_i);  // requester stalls with req still high
    @(posedge clk_i);
    lookup_req_i <= 1'b0;
    wait_ack(1'b1, 1'b0, ACK_DROP_LATENCY, "lookup ack fall");
  endtask

  task automatic finish_test(input string name);
    test_num++;
    if (test_errors == 0) begin
      tests_passed++;
      $display("test %0d %s: ok", test_num, name);
    end else begin
      tests_failed++;
      $display("test %0d %s: %0d mismatches", test_num, name, test_errors);
    end
    test_errors = 0;
  endtask

  // every cycle with ack high is compared, hold cycles included
  always @(negedge clk_i) begin
    if (rst_n_i === 1'b1 && lookup_ack_o === 1'b1) begin
      check_count++;
      if (lookup_rsp_o !== expected_rsp) begin
        error_count++;
        test_errors++;
        $display("CHECK FAILED at %0t: addr %h expected %s actual %s", $time, cur_addr,
                 rsp_text(expected_rsp), rsp_text(lookup_rsp_o));
      end
    end
  end

  initial begin
    logic [31:0]          r;
    logic [SET_WIDTH-1:0] set;
    logic [TAG_WIDTH-1:0] tag;
    logic [TAG_WIDTH-1:0] used;
    int                   base_checks;
    rst_n_i           = 1'b0;
    lookup_req_i      = 1'b0;
    lookup_req_data_i = '0;
    refill_req_i      = 1'b0;
    refill_data_i     = '0;
    rng_state         = 32'h2514_fc05;
    model_victim      = 0;
    check_count       = 0;
    error_count       = 0;
    test_errors       = 0;
    test_num          = 0;
    tests_passed      = 0;
    tests_failed      = 0;
    for (int s = 0; s < NUM_SETS; s++) begin
      for (int w = 0; w < NUM_WAYS; w++) model_valid[s][w] = 1'b0;
    end
    repeat (2) @(posedge clk_i);
    rst_n_i <= 1'b1;

    flush_all();
    for (int i = 0; i < 20; i++) begin
      r = next_rand();
      run_lookup(fetch_addr_t'(r), 0);
    end
    finish_test("no hits after full flush");

    for (int i = 0; i < 16; i++) begin
      r   = next_rand();
      set = r[SET_WIDTH-1:0];
      r   = next_rand();
      fill_tag(set, r[TAG_WIDTH-1:0], used);
      r   = next_rand();
      run_lookup(make_addr(used, set, r[OFFSET_WIDTH-1:0]), 0);
    end
    finish_test("fill then hit in victim way");

    flush_all();
    for (int i = 0; i < 8; i++) begin
      r   = next_rand();
      set = r[SET_WIDTH-1:0];
      if (set == '1) set = set - 1'b1;  // wrap case comes below
      r   = next_rand();
      fill_tag(set + 1'b1, r[TAG_WIDTH-1:0], used);
      run_lookup(make_addr(used, set, '0), 0);
    end
    r   = next_rand();
    tag = r[TAG_WIDTH-1:0];
    fill_tag('0, tag + 1'b1, used);  // set 0 with tag + 1
    run_lookup(make_addr(used - 1'b1, '1, 6'h3c), 0);
    finish_test("line B hit only, with wrap");

    flush_all();
    r   = next_rand();
    set = r[SET_WIDTH-1:0];
    while (model_victim != 0) begin
      r = next_rand();
      fill_tag(set ^ 6'h20, r[TAG_WIDTH-1:0], used);
    end
    r   = next_rand();
    tag = r[TAG_WIDTH-1:0];
    for (int i = 0; i < 5; i++) fill_tag(set, tag + TAG_WIDTH'(i), used);
    for (int i = 0; i < 5; i++) run_lookup(make_addr(tag + TAG_WIDTH'(i), set, '0), 0);
    finish_test("victim rotation over five fills");

    flush_all();
    r   = next_rand();
    set = r[SET_WIDTH-1:0];
    if (set == '0) set = 1;
    if (set == '1) set = set - 1'b1;
    r   = next_rand();
    tag = r[TAG_WIDTH-1:0];
    fill_tag(set - 1'b1, tag, used);
    fill_tag(set, tag, used);
    fill_tag(set + 1'b1, tag, used);
    run_refill(FLUSH, make_addr(tag, set, '0));
    run_lookup(make_addr(tag, set - 1'b1, '0), 0);
    run_lookup(make_addr(tag, set, '0), 0);
    run_lookup(make_addr(tag, set + 1'b1, '0), 0);
    finish_test("single set flush");

    r   = next_rand();
    set = r[SET_WIDTH-1:0];
    r   = next_rand();
    fill_tag(set, r[TAG_WIDTH-1:0], used);
    base_checks = check_count;
    run_lookup(make_addr(used, set, '0), HOLD_CYCLES);
    if (check_count - base_checks < HOLD_CYCLES + 1) begin
      error_count++;
      test_errors++;
      $display("lookup response was not compared on every cycle of the hold");
    end
    finish_test("ack and response held under back-pressure");

    $display("tests passed: %0d, tests failed: %0d, checks: %0d, errors: %0d",
             tests_passed, tests_failed, check_count, error_count);
    if (error_count == 0 && tests_failed == 0) begin
      $display("Simulation passed");
    end else begin
      $display("Simulation failed");
    end
    $finish;
  end

endmodule

// File: compile.f
design/icache_tag_pkg.sv
design/sram.sv
design/tag_array.sv
design/tag_lookup.sv
design/refill_ctrl.sv
design/icache_tag_top.sv
tests/tb_icache_tag.sv

// File: Bender.yml
package:
  name: icache_tag

sources:
  - files:
      - design/icache_tag_pkg.sv
      - design/sram.sv
      - design/tag_array.sv
      - design/tag_lookup.sv
      - design/refill_ctrl.sv
      - design/icache_tag_top.sv
  - target: test
    files:
      - tests/tb_icache_tag.sv
